/* Makefile */
VERILATOR ?= verilator
TOP       ?= cart_load_tb
FLIST     ?= all.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --timing --assert
JOBS      ?= 0

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FLIST) --top-module $(TOP)

$(BUILD_DIR)/V$(TOP): $(shell cat $(FLIST))
	$(VERILATOR) --binary $(VFLAGS) -j $(JOBS) -f $(FLIST) \
		--top-module $(TOP) --Mdir $(BUILD_DIR)

sim: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)

/* all.f */
design/load_pkg.sv
design/cart_pkg.sv
design/stream_reg.sv
design/dl_router.sv
design/header_sniffer.sv
design/cheat_assembler.sv
design/bank_mapper.sv
design/cart_load_top.sv
tests/cart_load_checker.sv
tests/cart_load_tb.sv

/* design/bank_mapper.sv */
`timescale 1ns/100ps
`default_nettype none

module bank_mapper (
	input  logic                 clk_sys,
	input  logic                 rst_n,
	input  logic                 rom_active,
	input  cart_pkg::cart_info_t cart_info,
	input  logic                 page_valid,
	input  cart_pkg::page_wr_t   page_wr,
	input  logic [23:1]          cpu_addr,
	output logic [23:1]          rom_addr
);

	logic [4:0] bank [8];
	logic       big_rom;

	assign big_rom = |cart_info.rom_mask[10:9];  // Over 4 MB

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < 8; i++) begin
				bank[i] <= 5'(i);
			end
		end else if (rom_active) begin
			for (int i = 0; i < 8; i++) begin
				bank[i] <= 5'(i);
			end
		end else if (page_valid) begin
			if (cart_info.pier_quirk) begin
				// Special title only pages the top half, four bit banks
				if ((page_wr.offset != 3'd0) && !page_wr.offset[2]) begin
					bank[{1'b1, page_wr.offset[1:0]}] <= {1'b0, page_wr.data[3:0]};
				end
			end else if (big_rom && (page_wr.offset != 3'd0)) begin
				bank[page_wr.offset] <= page_wr.data;
			end
		end
	end

	////////////////////////////////////////////////////////////////////
	// CPU to ROM word address, 512 KB pages
	////////////////////////////////////////////////////////////////////
	assign rom_addr = {bank[cpu_addr[21:19]], cpu_addr[18:1]} &
		{cart_info.rom_mask, 12'hFFF};

endmodule

`default_nettype wire

/* design/cart_load_top.sv */
`timescale 1ns/100ps
`default_nettype none

module cart_load_top (
	input  logic                  clk_sys,
	input  logic                  rst_n,
	input  load_pkg::dl_session_t session,
	input  logic                  dl_valid,
	output logic                  dl_ready,
	input  load_pkg::dl_word_t    dl_word,
	output logic                  mem_valid,
	input  logic                  mem_ready,
	output load_pkg::mem_wr_t     mem_wr,
	output logic                  code_valid,
	input  logic                  code_ready,
	output cart_pkg::cheat_code_t code,
	output cart_pkg::cart_info_t  cart_info,
	input  logic                  page_valid,
	input  cart_pkg::page_wr_t    page_wr,
	input  logic [23:1]           cpu_addr,
	output logic [23:1]           rom_addr
);

	import load_pkg::*;

	logic     rom_valid;
	logic     rom_ready;
	mem_wr_t  rom_wr;
	logic     cw_valid;        // Router side of the cheat stage
	logic     cw_ready;
	dl_word_t cw_word;
	logic     ca_valid;        // Assembler side
	logic     ca_ready;
	dl_word_t ca_word;
	logic     rom_seen;
	dl_word_t rom_seen_word;
	logic     rom_active;
	logic     cart_mode;

	dl_router u_router (
		.clk_sys         (clk_sys),
		.rst_n           (rst_n),
		.session         (session),
		.dl_valid        (dl_valid),
		.dl_ready        (dl_ready),
		.dl_word         (dl_word),
		.rom_valid       (rom_valid),
		.rom_ready       (rom_ready),
		.rom_wr          (rom_wr),
		.code_word_valid (cw_valid),
		.code_word_ready (cw_ready),
		.code_word       (cw_word),
		.rom_seen        (rom_seen),
		.rom_seen_word   (rom_seen_word),
		.rom_active      (rom_active),
		.cart_mode       (cart_mode)
	);

	// ROM word out to the memory port
	stream_reg #(.T(mem_wr_t)) u_mem_reg (
		.clk_sys   (clk_sys),
		.rst_n     (rst_n),
		.in_valid  (rom_valid),
		.in_ready  (rom_ready),
		.in_data   (rom_wr),
		.out_valid (mem_valid),
		.out_ready (mem_ready),
		.out_data  (mem_wr)
	);

	// Cheat words, one stage ahead of the assembler
	stream_reg #(.T(dl_word_t)) u_code_reg (
		.clk_sys   (clk_sys),
		.rst_n     (rst_n),
		.in_valid  (cw_valid),
		.in_ready  (cw_ready),
		.in_data   (cw_word),
		.out_valid (ca_valid),
		.out_ready (ca_ready),
		.out_data  (ca_word)
	);

	cheat_assembler u_cheat (
		.clk_sys    (clk_sys),
		.rst_n      (rst_n),
		.word_valid (ca_valid),
		.word_ready (ca_ready),
		.word       (ca_word),
		.code_valid (code_valid),
		.code_ready (code_ready),
		.code       (code)
	);

	header_sniffer u_sniffer (
		.clk_sys       (clk_sys),
		.rst_n         (rst_n),
		.rom_active    (rom_active),
		.cart_mode     (cart_mode),
		.rom_seen      (rom_seen),
		.rom_seen_word (rom_seen_word),
		.cart_info     (cart_info)
	);

	bank_mapper u_mapper (
		.clk_sys    (clk_sys),
		.rst_n      (rst_n),
		.rom_active (rom_active),
		.cart_info  (cart_info),
		.page_valid (page_valid),
		.page_wr    (page_wr),
		.cpu_addr   (cpu_addr),
		.rom_addr   (rom_addr)
	);

endmodule

`default_nettype wire

/* design/cart_pkg.sv */
`default_nettype none

package cart_pkg;

	typedef enum logic [1:0] {
		JP = 2'd0,
		US = 2'd1,
		EU = 2'd2
	} region_t;

	// Results of the header scan, rom_mask covers address bits 23..13
	typedef struct packed {
		logic        hdr_ready;
		region_t     region;
		logic [10:0] rom_mask;
		logic        cart_mode;
		logic        pier_quirk;
	} cart_info_t;

	// Big endian fields, target_mcd picks the CD side patcher
	typedef struct packed {
		logic        target_mcd;
		logic [31:0] flags;
		logic [31:0] address;
		logic [31:0] compare;
		logic [31:0] replace;
	} cheat_code_t;

	// Mapper register write
	typedef struct packed {
		logic [2:0] offset;
		logic [4:0] data;
	} page_wr_t;

	////////////////////////////////////////////////////////////////////
	// Cartridge header layout
	////////////////////////////////////////////////////////////////////
	localparam logic [24:0] HDR_REGION_ADDR = 25'h1F0;
	localparam logic [24:0] HDR_ID_FIRST    = 25'h182;
	localparam logic [24:0] HDR_ID_LAST     = 25'h18C;

	localparam logic [63:0] PIER_ID_A = "T-574023";  // Reprint
	localparam logic [63:0] PIER_ID_B = "T-574013";  // First edition

endpackage

`default_nettype wire

/* design/cheat_assembler.sv */
`timescale 1ns/100ps
`default_nettype none

module cheat_assembler (
	input  logic                  clk_sys,
	input  logic                  rst_n,
	input  logic                  word_valid,
	output logic                  word_ready,
	input  load_pkg::dl_word_t    word,
	output logic                  code_valid,
	input  logic                  code_ready,
	output cart_pkg::cheat_code_t code
);

	logic take;

	assign word_ready = ~code_valid;  // Stall while a finished code waits
	assign take       = word_valid & word_ready;

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			code_valid <= 1'b0;
		end else if (take && (word.addr[3:0] == 4'd14)) begin
			code_valid <= 1'b1;
		end else if (code_ready) begin
			code_valid <= 1'b0;
		end
	end

	// Low half first for every 32-bit field
	always_ff @(posedge clk_sys) begin
		if (take) begin
			case (word.addr[3:0])
				4'd0:  code.flags[15:0]    <= word.data;
				4'd2:  code.flags[31:16]   <= word.data;
				4'd4:  code.address[15:0]  <= word.data;
				4'd6:  code.address[31:16] <= word.data;
				4'd8:  code.compare[15:0]  <= word.data;
				4'd10: code.compare[31:16] <= word.data;
				4'd12: code.replace[15:0]  <= word.data;
				4'd14: begin
					code.replace[31:16] <= word.data;
					code.target_mcd     <= code.address[31];
				end
				default: ;  // Odd offsets carry nothing
			endcase
		end
	end

endmodule

`default_nettype wire

/* design/dl_router.sv */
`timescale 1ns/100ps
`default_nettype none

module dl_router (
	input  logic                   clk_sys,
	input  logic                   rst_n,
	input  load_pkg::dl_session_t  session,
	input  logic                   dl_valid,
	output logic                   dl_ready,
	input  load_pkg::dl_word_t     dl_word,
	output logic                   rom_valid,
	input  logic                   rom_ready,
	output load_pkg::mem_wr_t      rom_wr,
	output logic                   code_word_valid,
	input  logic                   code_word_ready,
	output load_pkg::dl_word_t     code_word,
	output logic                   rom_seen,
	output load_pkg::dl_word_t     rom_seen_word,
	output logic                   rom_active,
	output logic                   cart_mode
);

	import load_pkg::*;

	logic rom_dl;
	logic code_dl;
	logic rom_q;
	logic code_q;
	logic cart_q;
	logic rom_go;
	logic code_go;

	assign rom_dl  = session.active && (session.index[5:0] <= IDX_ROM_MAX);
	assign code_dl = session.active && (session.index == IDX_CODE);

	// Session kind settles one cycle before the first word is taken
	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			rom_q  <= 1'b0;
			code_q <= 1'b0;
			cart_q <= 1'b0;
		end else begin
			rom_q  <= rom_dl;
			code_q <= code_dl;
			if (rom_dl) begin
				cart_q <= session.index[IDX_CART_BIT];  // Held after the download
			end
		end
	end

	assign rom_go  = rom_dl & rom_q;
	assign code_go = code_dl & code_q;

	assign rom_valid       = dl_valid & rom_go;
	assign code_word_valid = dl_valid & code_go;
	assign dl_ready        = (rom_go & rom_ready) | (code_go & code_word_ready);

	////////////////////////////////////////////////////////////////////
	// ROM word mapping
	////////////////////////////////////////////////////////////////////
	always_comb begin
		if (cart_q) begin
			rom_wr.addr = {2'b00, dl_word.addr[22:1]};
		end else begin
			rom_wr.addr = BIOS_BASE | {6'd0, dl_word.addr[18:1]};
		end
		rom_wr.data = {dl_word.data[7:0], dl_word.data[15:8]};  // Host sends little endian
	end

	assign code_word = dl_word;

	assign rom_seen      = rom_valid & rom_ready;
	assign rom_seen_word = dl_word;
	assign rom_active    = rom_q;
	assign cart_mode     = cart_q;

endmodule

`default_nettype wire

/* design/header_sniffer.sv */
`timescale 1ns/100ps
`default_nettype none

module header_sniffer (
	input  logic                 clk_sys,
	input  logic                 rst_n,
	input  logic                 rom_active,
	input  logic                 cart_mode,
	input  logic                 rom_seen,
	input  load_pkg::dl_word_t   rom_seen_word,
	output cart_pkg::cart_info_t cart_info
);

	import cart_pkg::*;

	logic        rom_active_q;
	logic        rom_start;
	logic [63:0] cart_id;
	logic [7:0]  hdr_byte;

	assign rom_start = rom_active & ~rom_active_q;
	assign hdr_byte  = rom_seen_word.data[7:0];

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			rom_active_q         <= 1'b0;
			cart_info.hdr_ready  <= 1'b0;
			cart_info.region     <= JP;
			cart_info.rom_mask   <= '0;
			cart_info.cart_mode  <= 1'b0;
			cart_info.pier_quirk <= 1'b0;
		end else begin
			rom_active_q <= rom_active;

			// New ROM on the way, old header facts are stale
			if (rom_start) begin
				cart_info.hdr_ready  <= 1'b0;
				cart_info.region     <= JP;
				cart_info.pier_quirk <= 1'b0;
			end

			if (rom_seen) begin
				cart_info.cart_mode <= cart_mode;

				if (rom_seen_word.addr == HDR_REGION_ADDR) begin
					if (hdr_byte == "J") begin
						cart_info.region <= JP;
					end else if (hdr_byte == "U") begin
						cart_info.region <= US;
					end else begin
						cart_info.region <= EU;
					end
					cart_info.hdr_ready <= 1'b1;
				end

				if (cart_mode) begin
					// Size mask restarts with each image
					if (rom_seen_word.addr == '0) begin
						cart_info.rom_mask <= '0;
					end else begin
						cart_info.rom_mask <= cart_info.rom_mask | rom_seen_word.addr[23:13];
					end

					if (rom_seen_word.addr == HDR_ID_LAST) begin
						cart_info.pier_quirk <= (cart_id == PIER_ID_A) ||
							(cart_id == PIER_ID_B);
					end
				end
			end
		end
	end

	////////////////////////////////////////////////////////////////////
	// Cart ID capture, serial field starts mid word
	////////////////////////////////////////////////////////////////////
	always_ff @(posedge clk_sys) begin
		if (rom_seen && cart_mode) begin
			case (rom_seen_word.addr)
				HDR_ID_FIRST:          cart_id[63:56] <= rom_seen_word.data[15:8];
				HDR_ID_FIRST + 25'd2:  cart_id[55:40] <= {hdr_byte, rom_seen_word.data[15:8]};
				HDR_ID_FIRST + 25'd4:  cart_id[39:24] <= {hdr_byte, rom_seen_word.data[15:8]};
				HDR_ID_FIRST + 25'd6:  cart_id[23:8]  <= {hdr_byte, rom_seen_word.data[15:8]};
				HDR_ID_FIRST + 25'd8:  cart_id[7:0]   <= hdr_byte;
				default: ;
			endcase
		end
	end

endmodule

`default_nettype wire

/* design/load_pkg.sv */
`default_nettype none

package load_pkg;

	// Host download session, index as sent by the host
	typedef struct packed {
		logic       active;
		logic [7:0] index;
	} dl_session_t;

	// One 16-bit download word and its byte address
	typedef struct packed {
		logic [24:0] addr;
		logic [15:0] data;
	} dl_word_t;

	// Word write toward ROM memory
	typedef struct packed {
		logic [23:0] addr;
		logic [15:0] data;
	} mem_wr_t;

	localparam logic [5:0]  IDX_ROM_MAX  = 6'd1;      // Low index bits 0 and 1 are ROM
	localparam logic [7:0]  IDX_CODE     = 8'hFF;     // Cheat file
	localparam int          IDX_CART_BIT = 6;         // Set for cart, clear for BIOS
	localparam logic [23:0] BIOS_BASE    = 24'h780000;

endpackage

`default_nettype wire

/* design/stream_reg.sv */
`timescale 1ns/100ps
`default_nettype none

module stream_reg #(
	parameter type T = logic
) (
	input  logic clk_sys,
	input  logic rst_n,
	input  logic in_valid,
	output logic in_ready,
	input  T     in_data,
	output logic out_valid,
	input  logic out_ready,
	output T     out_data
);

	// Free when empty or when the held entry leaves this cycle
	assign in_ready = ~out_valid | out_ready;

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			out_valid <= 1'b0;
		end else if (in_ready) begin
			out_valid <= in_valid;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (in_valid && in_ready) begin
			out_data <= in_data;
		end
	end

endmodule

`default_nettype wire

/* tests/cart_load_checker.sv */
`timescale 1ns/100ps
`default_nettype none

module cart_load_checker (
	input logic                  clk_sys,
	input logic                  rst_n,
	input load_pkg::dl_session_t session,
	input logic                  dl_ready,
	input logic                  rom_valid,
	input logic                  rom_ready,
	input logic                  mem_valid,
	input logic                  mem_ready,
	input load_pkg::mem_wr_t     mem_wr,
	input logic                  code_valid,
	input logic                  code_ready,
	input cart_pkg::cheat_code_t code
);

	// Stalled payloads hold still
	mem_hold: assert property (@(posedge clk_sys) disable iff (!rst_n)
		mem_valid && !mem_ready |=> mem_valid && $stable(mem_wr))
		else $error("Memory write changed while stalled");

	code_hold: assert property (@(posedge clk_sys) disable iff (!rst_n)
		code_valid && !code_ready |=> code_valid && $stable(code))
		else $error("Cheat code changed while stalled");

	// Every memory word comes from a router acceptance
	mem_source: assert property (@(posedge clk_sys) disable iff (!rst_n)
		mem_valid |-> $past(rom_valid && rom_ready) || $past(mem_valid && !mem_ready))
		else $error("Memory write without an accepted word");

	idle_ready: assert property (@(posedge clk_sys) disable iff (!rst_n)
		!session.active |-> !dl_ready)
		else $error("Download ready with no session");

	reset_clear: assert property (@(posedge clk_sys)
		rst_n && !$past(rst_n) |-> !mem_valid && !code_valid)
		else $error("Valid outputs set right after reset");

endmodule

bind cart_load_top cart_load_checker u_checker (
	.clk_sys    (clk_sys),
	.rst_n      (rst_n),
	.session    (session),
	.dl_ready   (dl_ready),
	.rom_valid  (rom_valid),
	.rom_ready  (rom_ready),
	.mem_valid  (mem_valid),
	.mem_ready  (mem_ready),
	.mem_wr     (mem_wr),
	.code_valid (code_valid),
	.code_ready (code_ready),
	.code       (code)
);

`default_nettype wire

/* tests/cart_load_tb.sv */
`timescale 1ns/100ps
`default_nettype none

module cart_load_tb;

	import load_pkg::*;
	import cart_pkg::*;

	localparam int TIMEOUT_CYCLES = 20000;

	logic                  clk_sys;
	logic                  rst_n;
	dl_session_t           session;
	logic                  dl_valid;
	logic                  dl_ready;
	dl_word_t              dl_word;
	logic                  mem_valid;
	logic                  mem_ready;
	mem_wr_t               mem_wr;
	logic                  code_valid;
	logic                  code_ready;
	cheat_code_t           code;
	cart_info_t            cart_info;
	logic                  page_valid;
	page_wr_t              page_wr;
	logic [23:1]           cpu_addr;
	logic [23:1]           rom_addr;

	mem_wr_t     exp_q[$];   // Expected memory writes
	cheat_code_t code_q[$];
	logic [4:0]  bank_m [8];
	logic [10:0] mask_m;
	logic        cart_m;
	logic        rom_m;
	logic        quirk_m;
	int          cycles;
	int          seed;

	cart_load_top DUT (.*);

	initial begin
		clk_sys = 1'b0;
		forever #20 clk_sys = ~clk_sys;
	end

	task automatic report_failure(input string what);
		$display("%s", what);
		$display("Finished with errors");
		$fatal(1, "Simulation stopped");
	endtask

	task automatic check_eq(input string name, input logic [128:0] exp, input logic [128:0] act);
		assert (exp === act) else begin
			$display("MISMATCH %s expected %h actual %h", name, exp, act);
			$display("Finished with errors");
			$fatal(1, "Simulation stopped");
		end
	endtask

	always @(posedge clk_sys) begin
		cycles <= cycles + 1;
		if (cycles == TIMEOUT_CYCLES) begin
			report_failure("Timeout, the run did not complete in time");
		end
	end

	// Random back pressure on both output ports
	always @(posedge clk_sys) begin
		#2;
		mem_ready  = ($urandom % 4) != 0;
		code_ready = ($urandom % 3) == 0;
	end

	////////////////////////////////////////////////////////////////////
	// Scoreboards sample mid cycle before the transfer edge
	////////////////////////////////////////////////////////////////////
	always @(negedge clk_sys) begin
		if (rst_n && mem_valid && mem_ready) begin
			if (exp_q.size() == 0) begin
				report_failure("A memory write came out that was never sent");
			end
			check_eq("rom_word", exp_q.pop_front(), mem_wr);
		end
		if (rst_n && code_valid && code_ready) begin
			if (code_q.size() == 0) begin
				report_failure("A cheat code came out that was never sent");
			end
			check_eq("cheat_code", code_q.pop_front(), code);
		end
	end

	// All tasks start and end 2 ns after a rising edge
	task automatic start_session(input logic [7:0] idx);
		session = '{active: 1'b1, index: idx};
		rom_m   = (idx[5:0] <= 6'd1);
		if (rom_m) begin
			cart_m = idx[6];
			for (int i = 0; i < 8; i++) begin
				bank_m[i] = 5'(i);
			end
		end
		repeat (3) @(posedge clk_sys);
		#2;
	endtask

	task automatic end_session();
		while (exp_q.size() != 0 || code_q.size() != 0) begin
			@(posedge clk_sys);
		end
		#2;
		session.active = 1'b0;
		rom_m          = 1'b0;
		repeat (2) @(posedge clk_sys);
		#2;
	endtask

	task automatic send_word(input logic [24:0] addr, input logic [15:0] data);
		mem_wr_t exp;
		dl_valid = 1'b1;
		dl_word  = '{addr: addr, data: data};
		@(negedge clk_sys);
		while (!dl_ready) @(negedge clk_sys);
		if (rom_m) begin
			exp.addr = cart_m ? {2'b00, addr[22:1]} : {6'h1E, addr[18:1]};
			exp.data = {data[7:0], data[15:8]};
			exp_q.push_back(exp);
			if (cart_m) begin
				mask_m = (addr == '0) ? '0 : (mask_m | addr[23:13]);
			end
		end
		@(posedge clk_sys);
		#2;
		dl_valid = 1'b0;
	endtask

	task automatic send_burst(input int n, input logic [24:0] span);
		logic [24:0] a;
		for (int i = 0; i < n; i++) begin
			a = (25'($urandom) & span) | 25'h400;  // Clear of the header area
			send_word({a[24:1], 1'b0}, 16'($urandom));
		end
	endtask

	// Host words are little endian and the ID starts at byte 0x183
	task automatic send_header(input logic [63:0] id, input logic [7:0] letter);
		send_word(25'h182, {id[63:56], 8'h00});
		send_word(25'h184, {id[47:40], id[55:48]});
		send_word(25'h186, {id[31:24], id[39:32]});
		send_word(25'h188, {id[15:8], id[23:16]});
		send_word(25'h18A, {8'h00, id[7:0]});
		send_word(25'h18C, 16'h0000);
		send_word(25'h1F0, {8'h20, letter});
	endtask

	task automatic page_write(input logic [2:0] off, input logic [4:0] data);
		page_valid = 1'b1;
		page_wr    = '{offset: off, data: data};
		@(posedge clk_sys);
		#2;
		page_valid = 1'b0;
		if (quirk_m) begin
			if (off >= 3'd1 && off <= 3'd3) begin
				bank_m[3'd4 + {1'b0, off[1:0]}] = {1'b0, data[3:0]};
			end
		end else if ((mask_m[10] || mask_m[9]) && off != 3'd0) begin
			bank_m[off] = data;
		end
	endtask

	task automatic check_map(input int n);
		logic [23:1] a;
		logic [23:1] exp;
		for (int i = 0; i < n; i++) begin
			a        = 23'($urandom);
			cpu_addr = a;
			@(negedge clk_sys);
			exp = {bank_m[a[21:19]], a[18:1]} & {mask_m, 12'hFFF};
			check_eq("rom_addr", exp, rom_addr);
			@(posedge clk_sys);
			#2;
		end
	endtask

	task automatic check_header(input logic [1:0] region, input logic quirk);
		check_eq("hdr_ready", 1'b1, cart_info.hdr_ready);
		check_eq("region", region, cart_info.region);
		check_eq("rom_mask", mask_m, cart_info.rom_mask);
		check_eq("cart_mode", cart_m, cart_info.cart_mode);
		check_eq("pier_quirk", quirk, cart_info.pier_quirk);
		quirk_m = quirk;
	endtask

	task automatic send_cheat();
		logic [15:0] w [8];
		cheat_code_t exp;
		for (int i = 0; i < 8; i++) begin
			w[i] = 16'($urandom);
		end
		exp.target_mcd = w[3][15];
		exp.flags      = {w[1], w[0]};
		exp.address    = {w[3], w[2]};
		exp.compare    = {w[5], w[4]};
		exp.replace    = {w[7], w[6]};
		code_q.push_back(exp);
		start_session(8'hFF);
		for (int i = 0; i < 8; i++) begin
			send_word(25'(2 * i), w[i]);
		end
		end_session();
	endtask

	initial begin
		seed       = $urandom(32'h79fa);
		rst_n      = 1'b0;
		session    = '0;
		dl_valid   = 1'b0;
		dl_word    = '0;
		mem_ready  = 1'b0;
		code_ready = 1'b0;
		page_valid = 1'b0;
		page_wr    = '0;
		cpu_addr   = '0;
		cycles     = 0;
		mask_m     = '0;
		cart_m     = 1'b0;
		rom_m      = 1'b0;
		quirk_m    = 1'b0;
		for (int i = 0; i < 8; i++) begin
			bank_m[i] = 5'(i);
		end
		repeat (4) @(posedge clk_sys);
		#2;
		rst_n = 1'b1;
		check_eq("reset_valids", 2'b00, {mem_valid, code_valid});
		check_eq("reset_hdr", 1'b0, cart_info.hdr_ready);

		// Small cart image with an unknown ID and no banking
		start_session(8'h40);
		send_word(25'h0, 16'h1234);
		send_header("ABCDEFGH", "J");
		send_burst(40, 25'h3FFFFF);
		end_session();
		check_header(JP, 1'b0);
		page_write(3'd2, 5'd9);
		check_map(8);

		// BIOS image
		start_session(8'h00);
		check_eq("hdr_clear", 1'b0, cart_info.hdr_ready);
		send_header("BIOSBIOS", "U");
		send_burst(40, 25'h7FFFF);
		end_session();
		check_header(US, 1'b0);

		// 8 MB cart with free banking
		start_session(8'h40);
		send_word(25'h0, 16'hBEEF);
		send_word(25'h7FE000, 16'h5A5A);
		send_header("MEGAGAME", "E");
		send_burst(30, 25'h1FFFFFF);
		end_session();
		check_header(EU, 1'b0);
		for (int i = 0; i < 8; i++) begin
			page_write(3'(i), 5'($urandom));
		end
		check_map(24);

		// Special title image starts on identity banks
		start_session(8'h41);
		check_map(6);
		send_word(25'h0, 16'h0000);
		send_word(25'h3FE000, 16'hA5A5);
		send_header("T-574023", "U");
		send_burst(20, 25'h3FFFFF);
		end_session();
		check_header(US, 1'b1);
		for (int i = 0; i < 8; i++) begin
			page_write(3'(i), 5'($urandom));
		end
		check_map(24);

		send_cheat();
		send_cheat();
		send_cheat();

		$display("Finished with no errors");
		$finish;
	end

endmodule

`default_nettype wire
